//--- project.f
spmm_pkg.sv
spmm_weight_store.sv
spmm_gather.sv
spmm_mac.sv
spmm_top.sv
spmm_sva.sv
tb_spmm.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the spmm testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_spmm -f project.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -q "Regression passed" sim.log; then
  exit 0
else
  echo "simulation did not pass, see sim.log"
  exit 1
fi

//--- spmm_gather.sv
`default_nettype none

module spmm_gather
  import spmm_pkg::*;
#(
  parameter int DATA_WIDTH    = 8,
  parameter int W_NUM_OF_ROWS = 5,
  parameter int W_NUM_OF_COLS = 5
)(
  input  wire logic                                  clk,
  input  wire logic                                  rst_n_i,
  // nonzero stream in
  input  wire logic                                  nz_valid_i,
  output logic                                       nz_ready_o,
  input  wire logic [COL_IDX_WIDTH-1:0]              nz_col_i,
  input  wire logic [DATA_WIDTH-1:0]                 nz_value_i,
  input  wire logic                                  nz_last_i,
  input  wire logic                                  nz_empty_i,
  // weight store read
  output logic                                       rd_en_o,
  output logic      [COL_IDX_WIDTH-1:0]              rd_row_o,
  input  wire logic [W_NUM_OF_COLS*DATA_WIDTH-1:0]   rd_data_i,
  // to the mac stage
  output logic                                       g_valid_o,
  input  wire logic                                  g_ready_i,
  output logic      [DATA_WIDTH-1:0]                 g_value_o,
  output logic      [W_NUM_OF_COLS*DATA_WIDTH-1:0]   g_wrow_o,
  output logic                                       g_last_o,
  output logic                                       g_empty_o
);

  localparam int COL_IDX_WIDTH = (W_NUM_OF_ROWS > 1) ? $clog2(W_NUM_OF_ROWS) : 1;

  stage_state_e state_q;

  logic accept;
  logic take;

  // free slot, or the held beat leaves this cycle
  assign nz_ready_o = (state_q == ST_EMPTY) || g_ready_i;
  assign accept     = nz_valid_i && nz_ready_o;
  assign take       = (state_q == ST_FULL) && g_ready_i;

  // weight row fetch goes out with the accepted beat
  // empty rows carry no column, so no read for them
  assign rd_en_o  = accept && !nz_empty_i;
  assign rd_row_o = nz_col_i;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_EMPTY;
    end else if (accept) begin
      state_q <= ST_FULL;
    end else if (take) begin
      state_q <= ST_EMPTY;
    end
  end

  // beat fields, captured at the same edge the read is registered
  always_ff @(posedge clk) begin
    if (accept) begin
      g_value_o <= nz_value_i;
      g_last_o  <= nz_last_i;
      g_empty_o <= nz_empty_i;
    end
  end

  assign g_valid_o = (state_q == ST_FULL);

  // read data lines up with the registered fields and holds while stalled
  assign g_wrow_o = rd_data_i;

endmodule : spmm_gather

`default_nettype wire

//--- spmm_mac.sv
`default_nettype none

module spmm_mac
  import spmm_pkg::*;
#(
  parameter int DATA_WIDTH    = 8,
  parameter int W_NUM_OF_COLS = 5
)(
  input  wire logic                                  clk,
  input  wire logic                                  rst_n_i,
  // from the gather stage
  input  wire logic                                  g_valid_i,
  output logic                                       g_ready_o,
  input  wire logic [DATA_WIDTH-1:0]                 g_value_i,
  input  wire logic [W_NUM_OF_COLS*DATA_WIDTH-1:0]   g_wrow_i,
  input  wire logic                                  g_last_i,
  input  wire logic                                  g_empty_i,
  // finished rows out
  output logic                                       row_valid_o,
  input  wire logic                                  row_ready_i,
  output logic      [W_NUM_OF_COLS*DATA_WIDTH-1:0]   row_data_o
);

  // running sums, one per output column
  logic [W_NUM_OF_COLS-1:0][DATA_WIDTH-1:0] acc_q;
  // next value of each sum including the current beat
  logic [W_NUM_OF_COLS-1:0][DATA_WIDTH-1:0] sum;
  // finished row waiting on the result port
  logic [W_NUM_OF_COLS-1:0][DATA_WIDTH-1:0] out_q;

  stage_state_e out_state_q;

  logic take;
  logic out_load;
  logic out_drain;

  // only a last beat needs the output register
  // stall it while a finished row is still waiting
  assign g_ready_o = !g_last_i || (out_state_q == ST_EMPTY) || row_ready_i;
  assign take      = g_valid_i && g_ready_o;
  assign out_load  = take && g_last_i;
  assign out_drain = (out_state_q == ST_FULL) && row_ready_i;

  // multiply-add, wraps at DATA_WIDTH
  always_comb begin
    for (int k = 0; k < W_NUM_OF_COLS; k++) begin
      sum[k] = acc_q[k] + g_value_i * g_wrow_i[k*DATA_WIDTH +: DATA_WIDTH];
    end
  end

  // accumulators restart from zero as soon as a row completes
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      acc_q <= '0;
    end else if (take) begin
      if (g_last_i) begin
        acc_q <= '0;
      end else begin
        acc_q <= sum;
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_state_q <= ST_EMPTY;
    end else if (out_load) begin
      out_state_q <= ST_FULL;
    end else if (out_drain) begin
      out_state_q <= ST_EMPTY;
    end
  end

  // a row with no nonzeros finishes as all zeros
  always_ff @(posedge clk) begin
    if (out_load) begin
      out_q <= g_empty_i ? '0 : sum;
    end
  end

  assign row_valid_o = (out_state_q == ST_FULL);
  assign row_data_o  = out_q;

endmodule : spmm_mac

`default_nettype wire

//--- spmm_pkg.sv
`default_nettype none

package spmm_pkg;

  // opcode on the weight command port
  typedef enum logic {
    // store one element at (row, col)
    W_CMD_WRITE = 1'b0,
    // zero the whole weight matrix
    W_CMD_CLEAR = 1'b1
  } w_cmd_e;

  // occupancy of a one-entry stage register
  typedef enum logic {
    ST_EMPTY = 1'b0,
    ST_FULL  = 1'b1
  } stage_state_e;

endpackage : spmm_pkg

`default_nettype wire

//--- spmm_sva.sv
`default_nettype none

module spmm_sva #(
  parameter int DATA_WIDTH    = 8,
  parameter int W_NUM_OF_COLS = 5
)(
  input wire logic                                clk,
  input wire logic                                rst_n_i,
  input wire logic                                row_valid_o,
  input wire logic                                row_ready_i,
  input wire logic [W_NUM_OF_COLS*DATA_WIDTH-1:0] row_data_o
);

  timeunit 1ns;
  timeprecision 100ps;

  // a waiting result row holds until it is taken
  row_hold_a: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    (row_valid_o && !row_ready_i) |=> (row_valid_o && $stable(row_data_o))
  ) else $error("result row changed while waiting for row_ready_i");

  row_idle_after_reset_a: assert property (
    @(posedge clk) $rose(rst_n_i) |-> !row_valid_o
  ) else $error("row_valid_o high right after reset release");

  row_known_a: assert property (
    @(posedge clk) disable iff (!rst_n_i)
    row_valid_o |-> !$isunknown(row_data_o)
  ) else $error("row_data_o unknown while row_valid_o is high");

endmodule : spmm_sva

bind spmm_top spmm_sva #(
  .DATA_WIDTH    (DATA_WIDTH    ),
  .W_NUM_OF_COLS (W_NUM_OF_COLS )
) u_sva (
  .clk           (clk           ),
  .rst_n_i       (rst_n_i       ),
  .row_valid_o   (row_valid_o   ),
  .row_ready_i   (row_ready_i   ),
  .row_data_o    (row_data_o    )
);

`default_nettype wire

//--- spmm_top.sv
`default_nettype none

module spmm_top
  import spmm_pkg::*;
#(
  parameter int DATA_WIDTH    = 8,
  parameter int W_NUM_OF_ROWS = 5,
  parameter int W_NUM_OF_COLS = 5
)(
  input  wire logic                                  clk,
  input  wire logic                                  rst_n_i,
  // weight command port, always ready
  input  wire logic                                  wcmd_valid_i,
  input  wire w_cmd_e                                wcmd_op_i,
  input  wire logic [COL_IDX_WIDTH-1:0]              wcmd_row_i,
  input  wire logic [W_COL_IDX_WIDTH-1:0]            wcmd_col_i,
  input  wire logic [DATA_WIDTH-1:0]                 wcmd_data_i,
  // H nonzero stream
  input  wire logic                                  nz_valid_i,
  output logic                                       nz_ready_o,
  input  wire logic [COL_IDX_WIDTH-1:0]              nz_col_i,
  input  wire logic [DATA_WIDTH-1:0]                 nz_value_i,
  input  wire logic                                  nz_last_i,
  input  wire logic                                  nz_empty_i,
  // WH rows, element k in slice k
  output logic                                       row_valid_o,
  input  wire logic                                  row_ready_i,
  output logic      [W_NUM_OF_COLS*DATA_WIDTH-1:0]   row_data_o
);

  localparam int COL_IDX_WIDTH   = (W_NUM_OF_ROWS > 1) ? $clog2(W_NUM_OF_ROWS) : 1;
  localparam int W_COL_IDX_WIDTH = (W_NUM_OF_COLS > 1) ? $clog2(W_NUM_OF_COLS) : 1;

  // gather <-> weight store
  logic                                rd_en;
  logic [COL_IDX_WIDTH-1:0]            rd_row;
  logic [W_NUM_OF_COLS*DATA_WIDTH-1:0] rd_data;

  // gather -> mac
  logic                                g_valid;
  logic                                g_ready;
  logic [DATA_WIDTH-1:0]               g_value;
  logic [W_NUM_OF_COLS*DATA_WIDTH-1:0] g_wrow;
  logic                                g_last;
  logic                                g_empty;

  spmm_weight_store #(
    .DATA_WIDTH    (DATA_WIDTH    ),
    .W_NUM_OF_ROWS (W_NUM_OF_ROWS ),
    .W_NUM_OF_COLS (W_NUM_OF_COLS )
  ) u_wstore (
    .clk           (clk           ),
    .rst_n_i       (rst_n_i       ),
    .cmd_valid_i   (wcmd_valid_i  ),
    .cmd_op_i      (wcmd_op_i     ),
    .cmd_row_i     (wcmd_row_i    ),
    .cmd_col_i     (wcmd_col_i    ),
    .cmd_data_i    (wcmd_data_i   ),
    .rd_en_i       (rd_en         ),
    .rd_row_i      (rd_row        ),
    .rd_data_o     (rd_data       )
  );

  spmm_gather #(
    .DATA_WIDTH    (DATA_WIDTH    ),
    .W_NUM_OF_ROWS (W_NUM_OF_ROWS ),
    .W_NUM_OF_COLS (W_NUM_OF_COLS )
  ) u_gather (
    .clk           (clk           ),
    .rst_n_i       (rst_n_i       ),
    .nz_valid_i    (nz_valid_i    ),
    .nz_ready_o    (nz_ready_o    ),
    .nz_col_i      (nz_col_i      ),
    .nz_value_i    (nz_value_i    ),
    .nz_last_i     (nz_last_i     ),
    .nz_empty_i    (nz_empty_i    ),
    .rd_en_o       (rd_en         ),
    .rd_row_o      (rd_row        ),
    .rd_data_i     (rd_data       ),
    .g_valid_o     (g_valid       ),
    .g_ready_i     (g_ready       ),
    .g_value_o     (g_value       ),
    .g_wrow_o      (g_wrow        ),
    .g_last_o      (g_last        ),
    .g_empty_o     (g_empty       )
  );

  spmm_mac #(
    .DATA_WIDTH    (DATA_WIDTH    ),
    .W_NUM_OF_COLS (W_NUM_OF_COLS )
  ) u_mac (
    .clk           (clk           ),
    .rst_n_i       (rst_n_i       ),
    .g_valid_i     (g_valid       ),
    .g_ready_o     (g_ready       ),
    .g_value_i     (g_value       ),
    .g_wrow_i      (g_wrow        ),
    .g_last_i      (g_last        ),
    .g_empty_i     (g_empty       ),
    .row_valid_o   (row_valid_o   ),
    .row_ready_i   (row_ready_i   ),
    .row_data_o    (row_data_o    )
  );

endmodule : spmm_top

`default_nettype wire

//--- spmm_weight_store.sv
`default_nettype none

module spmm_weight_store
  import spmm_pkg::*;
#(
  parameter int DATA_WIDTH    = 8,
  parameter int W_NUM_OF_ROWS = 5,
  parameter int W_NUM_OF_COLS = 5
)(
  input  wire logic                                  clk,
  input  wire logic                                  rst_n_i,
  // command write port
  input  wire logic                                  cmd_valid_i,
  input  wire w_cmd_e                                cmd_op_i,
  input  wire logic [COL_IDX_WIDTH-1:0]              cmd_row_i,
  input  wire logic [W_COL_IDX_WIDTH-1:0]            cmd_col_i,
  input  wire logic [DATA_WIDTH-1:0]                 cmd_data_i,
  // row read port
  input  wire logic                                  rd_en_i,
  input  wire logic [COL_IDX_WIDTH-1:0]              rd_row_i,
  output logic      [W_NUM_OF_COLS*DATA_WIDTH-1:0]   rd_data_o
);

  // row index into W, same range as the H column index
  localparam int COL_IDX_WIDTH   = (W_NUM_OF_ROWS > 1) ? $clog2(W_NUM_OF_ROWS) : 1;
  // column index into W
  localparam int W_COL_IDX_WIDTH = (W_NUM_OF_COLS > 1) ? $clog2(W_NUM_OF_COLS) : 1;

  // W[row][col], one register per element
  logic [W_NUM_OF_ROWS-1:0][W_NUM_OF_COLS-1:0][DATA_WIDTH-1:0] w_q;

  logic cmd_in_range;
  logic rd_in_range;

  assign cmd_in_range = (cmd_row_i < W_NUM_OF_ROWS) && (cmd_col_i < W_NUM_OF_COLS);
  assign rd_in_range  = (rd_row_i < W_NUM_OF_ROWS);

  // commands land at this edge and are seen by reads from the next cycle
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      w_q <= '0;
    end else if (cmd_valid_i) begin
      case (cmd_op_i)
        W_CMD_WRITE: begin
          if (cmd_in_range) begin
            w_q[cmd_row_i][cmd_col_i] <= cmd_data_i;
          end
        end
        W_CMD_CLEAR: begin
          w_q <= '0;
        end
        default: begin
          w_q <= w_q;
        end
      endcase
    end
  end

  // registered row read, holds when idle
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      // an out-of-range row reads as zeros
      rd_data_o <= rd_in_range ? w_q[rd_row_i] : '0;
    end
  end

endmodule : spmm_weight_store

`default_nettype wire

//--- tb_spmm.sv
`default_nettype none

module tb_spmm
  import spmm_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int DW     = 8;
  localparam int NR     = 5;
  localparam int NC     = 5;
  localparam int COL_W  = $clog2(NR);
  localparam int WCOL_W = $clog2(NC);
  localparam int ROW_W  = NC * DW;

  logic              clk = 1'b0;
  logic              rst_n_i;
  logic              wcmd_valid_i;
  w_cmd_e            wcmd_op_i;
  logic [COL_W-1:0]  wcmd_row_i;
  logic [WCOL_W-1:0] wcmd_col_i;
  logic [DW-1:0]     wcmd_data_i;
  logic              nz_valid_i;
  logic              nz_ready_o;
  logic [COL_W-1:0]  nz_col_i;
  logic [DW-1:0]     nz_value_i;
  logic              nz_last_i;
  logic              nz_empty_i;
  logic              row_valid_o;
  logic              row_ready_i;
  logic [ROW_W-1:0]  row_data_o;

  integer seed;
  int     data_errs;
  int     proto_errs;
  int     rows_checked;
  bit     timed_out;

  // model of W and the pending beats and results
  logic [DW-1:0]    w_model [NR][NC];
  logic [COL_W-1:0] bq_col[$];
  logic [DW-1:0]    bq_val[$];
  bit               bq_last[$];
  bit               bq_empty[$];
  logic [ROW_W-1:0] exp_q[$];

  spmm_top uut (
    .clk          (clk          ),
    .rst_n_i      (rst_n_i      ),
    .wcmd_valid_i (wcmd_valid_i ),
    .wcmd_op_i    (wcmd_op_i    ),
    .wcmd_row_i   (wcmd_row_i   ),
    .wcmd_col_i   (wcmd_col_i   ),
    .wcmd_data_i  (wcmd_data_i  ),
    .nz_valid_i   (nz_valid_i   ),
    .nz_ready_o   (nz_ready_o   ),
    .nz_col_i     (nz_col_i     ),
    .nz_value_i   (nz_value_i   ),
    .nz_last_i    (nz_last_i    ),
    .nz_empty_i   (nz_empty_i   ),
    .row_valid_o  (row_valid_o  ),
    .row_ready_i  (row_ready_i  ),
    .row_data_o   (row_data_o   )
  );

  always #4 clk = ~clk;

  function automatic int rand_below(input int n);
    int r;
    r = $random(seed);
    return int'($unsigned(r) % n);
  endfunction

  // acc + value * W[c], each element wraps at DW bits
  function automatic logic [ROW_W-1:0] add_product(input logic [ROW_W-1:0] acc,
                                                   input logic [COL_W-1:0] c,
                                                   input logic [DW-1:0]    v);
    logic [ROW_W-1:0] res;
    logic [2*DW-1:0]  p;
    res = acc;
    for (int k = 0; k < NC; k++) begin
      p = v * w_model[c][k];
      res[k*DW +: DW] = res[k*DW +: DW] + p[DW-1:0];
    end
    return res;
  endfunction

  task automatic push_row(input bit allow_empty);
    int               n;
    logic [COL_W-1:0] c;
    logic [DW-1:0]    v;
    logic [ROW_W-1:0] e;
    e = '0;
    if (allow_empty && rand_below(8) == 0) begin
      // col and value are ignored on an empty beat
      bq_col.push_back(COL_W'(rand_below(NR)));
      bq_val.push_back(DW'(rand_below(256)));
      bq_last.push_back(1'b1);
      bq_empty.push_back(1'b1);
    end else begin
      n = 1 + rand_below(5);
      for (int i = 0; i < n; i++) begin
        c = COL_W'(rand_below(NR));
        v = DW'(rand_below(256));
        e = add_product(e, c, v);
        bq_col.push_back(c);
        bq_val.push_back(v);
        bq_last.push_back(i == n - 1);
        bq_empty.push_back(1'b0);
      end
    end
    exp_q.push_back(e);
  endtask

  task automatic write_random_weights();
    for (int r = 0; r < NR; r++) begin
      for (int c = 0; c < NC; c++) begin
        @(posedge clk);
        #1;
        wcmd_valid_i = 1'b1;
        wcmd_op_i    = W_CMD_WRITE;
        wcmd_row_i   = COL_W'(r);
        wcmd_col_i   = WCOL_W'(c);
        wcmd_data_i  = DW'(rand_below(256));
        w_model[r][c] = wcmd_data_i;
      end
    end
    @(posedge clk);
    #1;
    wcmd_valid_i = 1'b0;
  endtask

  task automatic clear_weights();
    @(posedge clk);
    #1;
    wcmd_valid_i = 1'b1;
    wcmd_op_i    = W_CMD_CLEAR;
    for (int r = 0; r < NR; r++) begin
      for (int c = 0; c < NC; c++) begin
        w_model[r][c] = '0;
      end
    end
    @(posedge clk);
    #1;
    wcmd_valid_i = 1'b0;
    wcmd_op_i    = W_CMD_WRITE;
  endtask

  // drive the queued beats, take results, optional random valid/ready gaps
  task automatic run_stream(input bit throttle, input int max_cycles);
    int cycles;
    int sent;
    int got;
    bit hold;
    cycles = 0;
    sent   = 0;
    got    = 0;
    hold   = 1'b0;
    if (!timed_out) begin
      while ((bq_col.size() > 0 || exp_q.size() > 0) && cycles < max_cycles) begin
        @(posedge clk);
        #1;
        // a beat that was not taken stays on the bus unchanged
        if (!hold) begin
          nz_valid_i = (bq_col.size() > 0) && (!throttle || rand_below(2) == 1);
        end
        if (bq_col.size() > 0) begin
          nz_col_i   = bq_col[0];
          nz_value_i = bq_val[0];
          nz_last_i  = bq_last[0];
          nz_empty_i = bq_empty[0];
        end
        row_ready_i = !throttle || (rand_below(2) == 1);
        #1;
        if (nz_valid_i && nz_ready_o) begin
          if (bq_last[0]) begin
            sent++;
          end
          void'(bq_col.pop_front());
          void'(bq_val.pop_front());
          void'(bq_last.pop_front());
          void'(bq_empty.pop_front());
          hold = 1'b0;
        end else begin
          hold = nz_valid_i;
        end
        if (row_valid_o && row_ready_i) begin
          got++;
          if (exp_q.size() == 0) begin
            proto_errs++;
            $display("a result row arrived with no row pending at %0t", $time);
          end else begin
            if (row_data_o !== exp_q[0]) begin
              data_errs++;
              $display("FAILED at %0t: row %0d got %h, expected %h", $time, rows_checked,
                       row_data_o, exp_q[0]);
            end
            void'(exp_q.pop_front());
            rows_checked++;
          end
        end
        cycles++;
      end
      if (bq_col.size() > 0 || exp_q.size() > 0) begin
        timed_out = 1'b1;
        $display("timeout: stream stuck with %0d beats and %0d rows outstanding",
                 bq_col.size(), exp_q.size());
      end else begin
        @(posedge clk);
        #1;
        nz_valid_i  = 1'b0;
        row_ready_i = 1'b1;
        // trailing rows are taken and counted too
        repeat (4) begin
          #1;
          if (row_valid_o) begin
            got++;
            $display("an extra result row appeared at %0t", $time);
          end
          @(posedge clk);
          #1;
        end
        if (sent != got) begin
          proto_errs++;
          $display("%0d rows were sent but %0d results came back", sent, got);
        end
      end
    end
  endtask

  // one-beat rows on an idle engine, result two cycles after the beat
  task automatic check_latency(input int n);
    logic [COL_W-1:0] c;
    logic [DW-1:0]    v;
    logic [ROW_W-1:0] e;
    for (int i = 0; i < n; i++) begin
      c = COL_W'(rand_below(NR));
      v = DW'(rand_below(256));
      e = add_product('0, c, v);
      @(posedge clk);
      #1;
      nz_valid_i  = 1'b1;
      nz_col_i    = c;
      nz_value_i  = v;
      nz_last_i   = 1'b1;
      nz_empty_i  = 1'b0;
      row_ready_i = 1'b1;
      #1;
      if (!nz_ready_o) begin
        proto_errs++;
        $display("FAILED at %0t: nz_ready_o low on an idle engine", $time);
      end
      @(posedge clk);
      #1;
      nz_valid_i = 1'b0;
      #1;
      if (row_valid_o) begin
        proto_errs++;
        $display("FAILED at %0t: row_valid_o high one cycle after the beat", $time);
      end
      @(posedge clk);
      #2;
      if (!row_valid_o) begin
        proto_errs++;
        $display("FAILED at %0t: row_valid_o low two cycles after the beat", $time);
      end else if (row_data_o !== e) begin
        data_errs++;
        $display("FAILED at %0t: row %0d got %h, expected %h", $time, rows_checked,
                 row_data_o, e);
      end
      rows_checked++;
      @(posedge clk);
      #2;
      if (row_valid_o) begin
        proto_errs++;
        $display("FAILED at %0t: row_valid_o still high after the result was taken", $time);
      end
    end
  endtask

  initial begin
    seed         = 32'h1236_d349;
    data_errs    = 0;
    proto_errs   = 0;
    rows_checked = 0;
    timed_out    = 1'b0;
    rst_n_i      = 1'b0;
    wcmd_valid_i = 1'b0;
    wcmd_op_i    = W_CMD_WRITE;
    wcmd_row_i   = '0;
    wcmd_col_i   = '0;
    wcmd_data_i  = '0;
    nz_valid_i   = 1'b0;
    nz_col_i     = '0;
    nz_value_i   = '0;
    nz_last_i    = 1'b0;
    nz_empty_i   = 1'b0;
    row_ready_i  = 1'b1;
    for (int r = 0; r < NR; r++) begin
      for (int c = 0; c < NC; c++) begin
        w_model[r][c] = '0;
      end
    end

    repeat (4) begin
      @(posedge clk);
      #1;
      if (row_valid_o) begin
        proto_errs++;
        $display("FAILED at %0t: row_valid_o high during reset", $time);
      end
    end
    rst_n_i = 1'b1;
    @(posedge clk);
    #2;
    if (!nz_ready_o || row_valid_o) begin
      proto_errs++;
      $display("FAILED at %0t: wrong handshake state after reset", $time);
    end

    write_random_weights();
    repeat (200) push_row(1'b1);
    run_stream(1'b0, 4000);
    repeat (100) push_row(1'b1);
    run_stream(1'b1, 4000);

    // all results are zero until W is written again
    clear_weights();
    repeat (20) push_row(1'b1);
    run_stream(1'b1, 1000);
    write_random_weights();
    repeat (30) push_row(1'b1);
    run_stream(1'b1, 1000);

    if (!timed_out) begin
      check_latency(10);
    end

    $display("rows checked %0d, data errors %0d, protocol errors %0d, timeout %0d",
             rows_checked, data_errs, proto_errs, timed_out);
    if (data_errs == 0 && proto_errs == 0 && !timed_out) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule : tb_spmm

`default_nettype wire
